// ==== filelist.f ====
+incdir+rtl
rtl/split_ctrl_pkg.sv
rtl/split_stream_pkg.sv
rtl/axis_skid_buffer.sv
rtl/packet_splitter.sv
rtl/split_op_merge.sv
rtl/packet_split_array.sv
sim/tb_packet_split_array.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_packet_split_array -f filelist.f
out=$(./obj_dir/Vtb_packet_split_array)
echo "$out"
if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

// ==== sim/tb_packet_split_array.sv ====
`timescale 1ns/10ps
`include "split_consts.svh"

module tb_packet_split_array;

  localparam int CHANNELS   = `SPLIT_CHANNELS;
  localparam int DW         = `SPLIT_DATA_WIDTH;
  localparam int KW         = `SPLIT_KEEP_WIDTH;
  localparam int WAIT_LIMIT = 5000;

  logic                       clk;
  logic                       rst;
  logic                       operation_start;
  split_ctrl_pkg::pckt_size_t pckt_size;
  logic                       external_error;
  logic                       operation_busy;
  logic                       operation_complete;
  logic                       operation_error;
  logic [CHANNELS-1:0]        transmission;
  logic [CHANNELS*DW-1:0]     s_axis_tdata;
  logic [CHANNELS*KW-1:0]     s_axis_tkeep;
  logic [CHANNELS-1:0]        s_axis_tvalid;
  logic [CHANNELS-1:0]        s_axis_tready;
  logic [CHANNELS-1:0]        s_axis_tlast;
  logic [CHANNELS*DW-1:0]     m_axis_tdata;
  logic [CHANNELS*KW-1:0]     m_axis_tkeep;
  logic [CHANNELS-1:0]        m_axis_tvalid;
  logic [CHANNELS-1:0]        m_axis_tready;
  logic [CHANNELS-1:0]        m_axis_tlast;

  // Beats waiting to be offered, and beats expected at the output
  split_stream_pkg::beat_t src_q[CHANNELS][$];
  split_stream_pkg::beat_t exp_q[CHANNELS][$];
  int          beat_cnt[CHANNELS];
  int          acc_cnt[CHANNELS];
  logic        open_pkt[CHANNELS];
  logic        blocked[CHANNELS];
  logic        fired[CHANNELS];
  int          eff_size;
  logic        gap_en;
  logic        bp_en;
  logic [31:0] data_rng;
  logic [31:0] gap_rng;
  string       cur_test;
  int          err_cnt;
  int          err_start;
  int          tests_run;
  int          tests_failed;

  packet_split_array #(
    .CHANNELS (CHANNELS)
  ) packet_split_array_i (
    .clk                (clk),
    .rst                (rst),
    .operation_start    (operation_start),
    .pckt_size          (pckt_size),
    .external_error     (external_error),
    .operation_busy     (operation_busy),
    .operation_complete (operation_complete),
    .operation_error    (operation_error),
    .transmission       (transmission),
    .s_axis_tdata       (s_axis_tdata),
    .s_axis_tkeep       (s_axis_tkeep),
    .s_axis_tvalid      (s_axis_tvalid),
    .s_axis_tready      (s_axis_tready),
    .s_axis_tlast       (s_axis_tlast),
    .m_axis_tdata       (m_axis_tdata),
    .m_axis_tkeep       (m_axis_tkeep),
    .m_axis_tvalid      (m_axis_tvalid),
    .m_axis_tready      (m_axis_tready),
    .m_axis_tlast       (m_axis_tlast)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Stream contents and sizes
  function automatic int pick(int n);
    data_rng = xorshift32(data_rng);
    return int'(data_rng % n);
  endfunction

  // Valid gaps and output stalls
  function automatic int gap_pick(int n);
    gap_rng = xorshift32(gap_rng);
    return int'(gap_rng % n);
  endfunction

  task automatic report_problem(string text);
    err_cnt++;
    $display("%s: %s", cur_test, text);
  endtask

  task automatic check_beat(string name, split_stream_pkg::beat_t exp,
                            split_stream_pkg::beat_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERR %s: expected data=%h keep=%h last=%b, actual data=%h keep=%h last=%b",
               name, exp.data, exp.keep, exp.last, act.data, act.keep, act.last);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Source side holding one beat per channel until it is taken
  always begin : drive
    logic hold;
    @(posedge clk);
    #1;
    for (int k = 0; k < CHANNELS; k++) begin
      m_axis_tready[k] = bp_en ? (gap_pick(3) != 0) : 1'b1;
      hold = s_axis_tvalid[k] && !fired[k] && (src_q[k].size() > 0);
      if (!hold) begin
        if (src_q[k].size() > 0 && (!gap_en || gap_pick(4) != 0)) begin
          s_axis_tvalid[k]         = 1'b1;
          s_axis_tdata[k*DW +: DW] = src_q[k][0].data;
          s_axis_tkeep[k*KW +: KW] = src_q[k][0].keep;
          s_axis_tlast[k]          = src_q[k][0].last;
        end else begin
          s_axis_tvalid[k] = 1'b0;
        end
      end
    end
  end

  // Model and output checks sampled mid-cycle
  always begin : monitor
    split_stream_pkg::beat_t b;
    split_stream_pkg::beat_t e;
    split_stream_pkg::beat_t act;
    @(negedge clk);
    if (!rst) begin
      for (int k = 0; k < CHANNELS; k++) begin
        check_flag($sformatf("%s transmission[%0d]", cur_test, k), open_pkt[k],
                   transmission[k]);
        if (blocked[k] && s_axis_tready[k]) begin
          report_problem($sformatf("s_axis_tready[%0d] is high after its stream ended", k));
        end
        if (m_axis_tvalid[k] && m_axis_tready[k]) begin
          act.data = m_axis_tdata[k*DW +: DW];
          act.keep = m_axis_tkeep[k*KW +: KW];
          act.last = m_axis_tlast[k];
          if (exp_q[k].size() == 0) begin
            report_problem($sformatf("channel %0d sent a beat that was never accepted", k));
          end else begin
            check_beat(cur_test, exp_q[k].pop_front(), act);
          end
        end
        fired[k] = s_axis_tvalid[k] && s_axis_tready[k];
        if (fired[k] && src_q[k].size() == 0) begin
          report_problem($sformatf("channel %0d took a beat that was not offered", k));
        end else if (fired[k]) begin
          b      = src_q[k].pop_front();
          e.data = b.data;
          e.keep = b.keep;
          // Packet closes on the size boundary or on the input tlast
          e.last = (beat_cnt[k] == eff_size - 1) || b.last;
          beat_cnt[k] = e.last ? 0 : beat_cnt[k] + 1;
          open_pkt[k] = !e.last;
          acc_cnt[k]++;
          if (b.last) begin
            blocked[k] = 1'b1;
          end
          exp_q[k].push_back(e);
        end
        if (external_error) begin
          open_pkt[k] = 1'b0;
          blocked[k]  = 1'b1;
        end
        // New operation where zero size counts as one beat
        if (operation_start) begin
          beat_cnt[k] = 0;
          acc_cnt[k]  = 0;
          blocked[k]  = 1'b0;
          eff_size    = (pckt_size == '0) ? 1 : int'(pckt_size);
        end
      end
    end
  end

  task automatic start_op(int size);
    @(posedge clk);
    #1;
    pckt_size       = split_ctrl_pkg::pckt_size_t'(size);
    operation_start = 1'b1;
    @(posedge clk);
    #1;
    operation_start = 1'b0;
  endtask

  task automatic load_stream(int k, int n);
    split_stream_pkg::beat_t b;
    for (int i = 0; i < n; i++) begin
      data_rng = xorshift32(data_rng);
      b.data   = split_stream_pkg::data_t'(data_rng);
      b.keep   = split_stream_pkg::keep_t'(pick(1 << KW));
      b.last   = (i == n - 1);
      src_q[k].push_back(b);
    end
  endtask

  task automatic flush_sources();
    for (int k = 0; k < CHANNELS; k++) begin
      src_q[k].delete();
    end
  endtask

  // Waits for the first status pulse and checks it lasts one cycle
  task automatic wait_pulse(string name, logic exp_complete, logic exp_error);
    logic seen;
    seen = 1'b0;
    for (int cyc = 0; cyc < WAIT_LIMIT && !seen; cyc++) begin
      @(negedge clk);
      if (operation_complete || operation_error) begin
        seen = 1'b1;
        check_flag({name, " operation_complete"}, exp_complete, operation_complete);
        check_flag({name, " operation_error"}, exp_error, operation_error);
        for (int k = 0; k < CHANNELS; k++) begin
          if (exp_complete && src_q[k].size() != 0) begin
            report_problem($sformatf("completion came before channel %0d finished", k));
          end
        end
      end else if (exp_complete) begin
        check_flag({name, " operation_busy"}, 1'b1, operation_busy);
      end
    end
    if (!seen) begin
      report_problem("timed out waiting for a completion or error pulse");
    end else begin
      @(negedge clk);
      check_flag({name, " complete after pulse"}, 1'b0, operation_complete);
      check_flag({name, " error after pulse"}, 1'b0, operation_error);
    end
  endtask

  task automatic wait_accepted(int k, int n);
    int cyc;
    cyc = 0;
    while (acc_cnt[k] < n && cyc < WAIT_LIMIT) begin
      @(negedge clk);
      cyc++;
    end
    if (acc_cnt[k] < n) begin
      report_problem($sformatf("timed out waiting for input beats on channel %0d", k));
    end
  endtask

  task automatic wait_drain();
    logic empty;
    empty = 1'b0;
    for (int cyc = 0; cyc < WAIT_LIMIT && !empty; cyc++) begin
      @(negedge clk);
      empty = (m_axis_tvalid == '0);
      for (int k = 0; k < CHANNELS; k++) begin
        if (exp_q[k].size() != 0) begin
          empty = 1'b0;
        end
      end
    end
    if (!empty) begin
      report_problem("timed out waiting for the output streams to drain");
    end
  endtask

  task automatic begin_test(string name, logic gaps, logic bp);
    cur_test  = name;
    err_start = err_cnt;
    gap_en    = gaps;
    bp_en     = bp;
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (err_cnt == err_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, err_cnt - err_start);
    end
  endtask

  // Channel 0 gets beats0 and every other channel beats1
  task automatic run_case(string name, int size, int beats0, int beats1,
                          logic gaps, logic bp, logic exp_error);
    begin_test(name, gaps, bp);
    start_op(size);
    for (int k = 0; k < CHANNELS; k++) begin
      load_stream(k, (k == 0) ? beats0 : beats1);
    end
    wait_pulse(name, !exp_error, exp_error);
    if (exp_error) begin
      flush_sources();
    end
    wait_drain();
    end_test(name);
  endtask

  task automatic run_external_error(string name);
    int size;
    begin_test(name, 1'b1, 1'b0);
    size = 2 + pick(5);
    start_op(size);
    for (int k = 0; k < CHANNELS; k++) begin
      load_stream(k, size * 20);
    end
    wait_accepted(0, 5);
    @(posedge clk);
    #1;
    external_error = 1'b1;
    flush_sources();
    @(posedge clk);
    #1;
    external_error = 1'b0;
    wait_pulse(name, 1'b0, 1'b1);
    // Inputs must stay blocked while no new start arrives
    repeat (20) @(posedge clk);
    wait_drain();
    end_test(name);
  endtask

  initial begin
    int sz;
    int n;
    rst             = 1'b1;
    operation_start = 1'b0;
    pckt_size       = '0;
    external_error  = 1'b0;
    s_axis_tdata    = '0;
    s_axis_tkeep    = '0;
    s_axis_tvalid   = '0;
    s_axis_tlast    = '0;
    m_axis_tready   = '0;
    data_rng        = 32'd24110;
    gap_rng         = xorshift32(32'd24110);
    err_cnt         = 0;
    tests_run       = 0;
    tests_failed    = 0;
    eff_size        = 1;
    for (int k = 0; k < CHANNELS; k++) begin
      beat_cnt[k] = 0;
      acc_cnt[k]  = 0;
      open_pkt[k] = 1'b0;
      blocked[k]  = 1'b0;
      fired[k]    = 1'b0;
    end
    begin_test("reset", 1'b0, 1'b0);
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_flag("reset operation_busy", 1'b0, operation_busy);
    check_flag("reset operation_complete", 1'b0, operation_complete);
    check_flag("reset operation_error", 1'b0, operation_error);
    for (int k = 0; k < CHANNELS; k++) begin
      check_flag($sformatf("reset s_axis_tready[%0d]", k), 1'b0, s_axis_tready[k]);
      check_flag($sformatf("reset m_axis_tvalid[%0d]", k), 1'b0, m_axis_tvalid[k]);
    end
    end_test("reset");

    sz = 1 + pick(6);
    run_case("divisible", sz, sz * (2 + pick(4)), sz * (2 + pick(4)), 1'b0, 1'b0, 1'b0);
    sz = 2 + pick(6);
    run_case("back_pressure", sz, sz * (3 + pick(4)), sz * (3 + pick(4)), 1'b1, 1'b1, 1'b0);
    // Ends between one and size-1 beats into a packet
    sz = 2 + pick(5);
    n  = sz * (1 + pick(3)) + 1 + pick(sz - 1);
    run_case("non_divisible", sz, n, 0, 1'b1, 1'b0, 1'b1);
    run_external_error("external_error");
    sz = 2 + pick(4);
    run_case("locking", sz, sz * 2, sz * 12, 1'b1, 1'b0, 1'b0);
    sz = 3 + pick(6);
    run_case("transmission", sz, sz * (3 + pick(3)), sz * (3 + pick(3)), 1'b1, 1'b1, 1'b0);
    run_case("zero_size", 0, 3 + pick(6), 3 + pick(6), 1'b1, 1'b1, 1'b0);

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== rtl/packet_split_array.sv ====
`timescale 1ns/10ps
`include "split_consts.svh"

module packet_split_array #(
  parameter int CHANNELS = `SPLIT_CHANNELS
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  operation_start,
  input  split_ctrl_pkg::pckt_size_t            pckt_size,
  input  logic                                  external_error,
  output logic                                  operation_busy,
  output logic                                  operation_complete,
  output logic                                  operation_error,
  output logic [CHANNELS-1:0]                   transmission,
  input  logic [CHANNELS*`SPLIT_DATA_WIDTH-1:0] s_axis_tdata,
  input  logic [CHANNELS*`SPLIT_KEEP_WIDTH-1:0] s_axis_tkeep,
  input  logic [CHANNELS-1:0]                   s_axis_tvalid,
  output logic [CHANNELS-1:0]                   s_axis_tready,
  input  logic [CHANNELS-1:0]                   s_axis_tlast,
  output logic [CHANNELS*`SPLIT_DATA_WIDTH-1:0] m_axis_tdata,
  output logic [CHANNELS*`SPLIT_KEEP_WIDTH-1:0] m_axis_tkeep,
  output logic [CHANNELS-1:0]                   m_axis_tvalid,
  input  logic [CHANNELS-1:0]                   m_axis_tready,
  output logic [CHANNELS-1:0]                   m_axis_tlast
);

  logic [CHANNELS-1:0] running;
  logic [CHANNELS-1:0] done;
  logic [CHANNELS-1:0] fault;
  logic [CHANNELS-1:0] lock;
  logic                abort;

  for (genvar k = 0; k < CHANNELS; k++) begin : gen_chan
    split_stream_pkg::beat_t split_beat;
    logic                    split_valid;
    logic                    split_ready;
    split_stream_pkg::beat_t out_beat;

    packet_splitter packet_splitter_i (
      .clk          (clk),
      .rst          (rst),
      .start        (operation_start),
      .pckt_size    (pckt_size),
      .lock         (lock[k]),
      .abort        (abort),
      .s_tdata      (s_axis_tdata[k*`SPLIT_DATA_WIDTH +: `SPLIT_DATA_WIDTH]),
      .s_tkeep      (s_axis_tkeep[k*`SPLIT_KEEP_WIDTH +: `SPLIT_KEEP_WIDTH]),
      .s_tvalid     (s_axis_tvalid[k]),
      .s_tready     (s_axis_tready[k]),
      .s_tlast      (s_axis_tlast[k]),
      .out_beat     (split_beat),
      .out_valid    (split_valid),
      .out_ready    (split_ready),
      .running      (running[k]),
      .done         (done[k]),
      .fault        (fault[k]),
      .transmission (transmission[k])
    );

    axis_skid_buffer axis_skid_buffer_i (
      .clk       (clk),
      .rst       (rst),
      .in_beat   (split_beat),
      .in_valid  (split_valid),
      .in_ready  (split_ready),
      .out_beat  (out_beat),
      .out_valid (m_axis_tvalid[k]),
      .out_ready (m_axis_tready[k])
    );

    // Output slice of the flat buses
    assign m_axis_tdata[k*`SPLIT_DATA_WIDTH +: `SPLIT_DATA_WIDTH] = out_beat.data;
    assign m_axis_tkeep[k*`SPLIT_KEEP_WIDTH +: `SPLIT_KEEP_WIDTH] = out_beat.keep;
    assign m_axis_tlast[k]                                        = out_beat.last;
  end

  split_op_merge #(
    .CHANNELS (CHANNELS)
  ) split_op_merge_i (
    .clk                (clk),
    .rst                (rst),
    .external_error     (external_error),
    .running            (running),
    .done               (done),
    .fault              (fault),
    .lock               (lock),
    .abort              (abort),
    .operation_busy     (operation_busy),
    .operation_complete (operation_complete),
    .operation_error    (operation_error)
  );

endmodule

// ==== rtl/split_op_merge.sv ====
`timescale 1ns/10ps

module split_op_merge #(
  parameter int CHANNELS = 2
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                external_error,
  input  logic [CHANNELS-1:0] running,
  input  logic [CHANNELS-1:0] done,
  input  logic [CHANNELS-1:0] fault,
  output logic [CHANNELS-1:0] lock,
  output logic                abort,
  output logic                operation_busy,
  output logic                operation_complete,
  output logic                operation_error
);

  logic all_done;
  logic error_cond;
  logic error_q;

  assign all_done   = &done;
  assign error_cond = (|fault) || external_error;

  // Any fault stops every channel
  assign abort = error_cond;

  // Early finishers wait in done until the last channel arrives
  assign lock = all_done ? '0 : done;

  // Channels waiting under lock still count as busy
  assign operation_busy = |(running | done);

  always_ff @(posedge clk) begin
    if (rst) begin
      operation_complete <= 1'b0;
      operation_error    <= 1'b0;
      error_q            <= 1'b0;
    end else begin
      // All-done lasts one cycle since unlocked channels return to idle
      operation_complete <= all_done && !error_cond;
      // Rising edge only since an abort can keep faults up for a few cycles
      operation_error    <= error_cond && !error_q;
      error_q            <= error_cond;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    !(operation_complete && operation_error))
    else $error("split_op_merge: complete and error in the same cycle");

endmodule

// ==== rtl/packet_splitter.sv ====
`timescale 1ns/10ps
`include "split_consts.svh"

module packet_splitter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  split_ctrl_pkg::pckt_size_t pckt_size,
  input  logic                       lock,
  input  logic                       abort,
  input  split_stream_pkg::data_t    s_tdata,
  input  split_stream_pkg::keep_t    s_tkeep,
  input  logic                       s_tvalid,
  output logic                       s_tready,
  input  logic                       s_tlast,
  output split_stream_pkg::beat_t    out_beat,
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic                       running,
  output logic                       done,
  output logic                       fault,
  output logic                       transmission
);

  split_ctrl_pkg::split_state_e state;
  split_ctrl_pkg::pckt_size_t   size_lat;
  split_ctrl_pkg::pckt_size_t   beat_cnt;
  logic                         in_run;
  logic                         in_fire;
  logic                         at_boundary;
  logic                         off_boundary_end;

  assign in_run = (state == split_ctrl_pkg::state_run);

  // Pass-through path with the skid buffer as the register stage
  assign s_tready  = in_run && out_ready && !abort;
  assign out_valid = in_run && s_tvalid && !abort;
  assign in_fire   = s_tvalid && s_tready;

  // Last beat of the current output packet
  assign at_boundary = (beat_cnt == size_lat - 1'b1);

  assign out_beat.data = s_tdata;
  assign out_beat.keep = s_tkeep;
  assign out_beat.last = at_boundary || s_tlast;

  // Input ends in the middle of an output packet
  assign off_boundary_end = s_tlast && !at_boundary &&
                            (`SPLIT_RAISE_NON_DIVISIBLE != 0);

  // Size is captured once per operation and zero counts as one beat
  always_ff @(posedge clk) begin
    if (state == split_ctrl_pkg::state_idle && start) begin
      if (pckt_size == '0) begin
        size_lat <= split_ctrl_pkg::pckt_size_t'(1);
      end else begin
        size_lat <= pckt_size;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= split_ctrl_pkg::state_idle;
      beat_cnt <= '0;
    end else begin
      case (state)
        split_ctrl_pkg::state_idle: begin
          if (start) begin
            state    <= split_ctrl_pkg::state_run;
            beat_cnt <= '0;
          end
        end
        split_ctrl_pkg::state_run: begin
          if (abort) begin
            state <= split_ctrl_pkg::state_fault;
          end else if (in_fire) begin
            if (out_beat.last) begin
              beat_cnt <= '0;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
            // Input tlast ends the channel's operation
            if (s_tlast) begin
              if (off_boundary_end) begin
                state <= split_ctrl_pkg::state_fault;
              end else begin
                state <= split_ctrl_pkg::state_done;
              end
            end
          end
        end
        split_ctrl_pkg::state_done: begin
          // Held here until the other channels catch up
          if (abort) begin
            state <= split_ctrl_pkg::state_fault;
          end else if (!lock) begin
            state <= split_ctrl_pkg::state_idle;
          end
        end
        default: begin
          state <= split_ctrl_pkg::state_idle;
        end
      endcase
    end
  end

  // Open output packet flag
  always_ff @(posedge clk) begin
    if (rst) begin
      transmission <= 1'b0;
    end else if (abort) begin
      transmission <= 1'b0;
    end else if (in_fire) begin
      transmission <= !out_beat.last;
    end
  end

  assign running = in_run;
  assign done    = (state == split_ctrl_pkg::state_done);
  assign fault   = (state == split_ctrl_pkg::state_fault);

  // Channel leaves run once its input tlast is taken
  assert property (@(posedge clk) disable iff (rst)
    in_fire && s_tlast |=> !s_tready)
    else $error("packet_splitter: s_tready high after input tlast");

endmodule

// ==== rtl/axis_skid_buffer.sv ====
`timescale 1ns/10ps

module axis_skid_buffer (
  input  logic                    clk,
  input  logic                    rst,
  input  split_stream_pkg::beat_t in_beat,
  input  logic                    in_valid,
  output logic                    in_ready,
  output split_stream_pkg::beat_t out_beat,
  output logic                    out_valid,
  input  logic                    out_ready
);

  split_stream_pkg::beat_t main_beat;
  split_stream_pkg::beat_t skid_beat;
  logic                    main_valid;
  logic                    skid_valid;
  logic                    in_fire;
  logic                    main_load;
  logic                    main_valid_next;
  logic                    skid_valid_next;

  assign in_fire = in_valid && in_ready;

  // Main register may take a new beat when empty or draining
  assign main_load = !main_valid || out_ready;

  // in_ready is low whenever the skid entry is full,
  // so skid data and a new input never compete for main
  assign main_valid_next = main_load ? (skid_valid || in_fire) : 1'b1;
  assign skid_valid_next = main_load ? 1'b0 : (skid_valid || in_fire);

  always_ff @(posedge clk) begin
    if (rst) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end else begin
      main_valid <= main_valid_next;
      skid_valid <= skid_valid_next;
      in_ready   <= !skid_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) begin
      if (skid_valid) begin
        main_beat <= skid_beat;
      end else if (in_fire) begin
        main_beat <= in_beat;
      end
    end
    // Beat arrives while main is stalled
    if (!main_load && in_fire) begin
      skid_beat <= in_beat;
    end
  end

  assign out_beat  = main_beat;
  assign out_valid = main_valid;

  // Stalled output beat must be held until taken
  assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else $error("axis_skid_buffer: output beat changed while stalled");

endmodule

// ==== rtl/split_stream_pkg.sv ====
`include "split_consts.svh"

package split_stream_pkg;

  // One channel's payload fields
  typedef logic [`SPLIT_DATA_WIDTH-1:0] data_t;
  typedef logic [`SPLIT_KEEP_WIDTH-1:0] keep_t;

  // Output beat as it is stored in the skid buffer
  typedef struct packed {
    data_t data;
    keep_t keep;
    logic  last;
  } beat_t;

endpackage

// ==== rtl/split_ctrl_pkg.sv ====
`include "split_consts.svh"

package split_ctrl_pkg;

  // Packet size in beats where zero is taken as one
  typedef logic [`SPLIT_PCKT_WIDTH-1:0] pckt_size_t;

  // Channel FSM states
  typedef enum logic [1:0] {
    state_idle  = 2'd0,
    state_run   = 2'd1,
    // Finished, may be held here by lock
    state_done  = 2'd2,
    // One cycle on the way back to idle after an error
    state_fault = 2'd3
  } split_state_e;

endpackage

// ==== rtl/split_consts.svh ====
`ifndef SPLIT_CONSTS_SVH
`define SPLIT_CONSTS_SVH

// Number of stream channels in the default build
`define SPLIT_CHANNELS 2

// Per-channel stream widths
`define SPLIT_DATA_WIDTH 16
`define SPLIT_KEEP_WIDTH (`SPLIT_DATA_WIDTH / 8)

// Width of the packet size value, in beats
`define SPLIT_PCKT_WIDTH 16

// Flag an input that ends off a packet boundary
`define SPLIT_RAISE_NON_DIVISIBLE 1

`endif
